//--- bench/mempool_system_assert.sv
//********************************************************************
// MemPool system assertions
// Bus handshake timing and control output checks on the top level
//********************************************************************
`timescale 1ns/1ns
module mempool_system_assert (
  input logic                               clk_i,
  input logic                               arst_n_i,
  input logic [mempool_pkg::NumMasters-1:0] req_i,
  input logic [mempool_pkg::NumMasters-1:0] gnt_i,
  input logic [mempool_pkg::NumMasters-1:0] rvalid_i,
  input logic                               eoc_valid_i,
  input logic [mempool_pkg::NumCores-1:0]   wake_up_i
);
  import mempool_pkg::*;

  for (genvar m = 0; m < NumMasters; m++) begin : gen_mst
    gnt_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      gnt_i[m] |-> req_i[m])
      else $error("grant without request on master %0d", m);

    // Response exactly one cycle after each accepted request
    rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (req_i[m] && gnt_i[m]) |=> rvalid_i[m])
      else $error("missing response on master %0d", m);

    rvalid_needs_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rvalid_i[m] |-> $past(req_i[m] && gnt_i[m]))
      else $error("response without grant on master %0d", m);
  end

  wake_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (|wake_up_i) |=> !(|wake_up_i))
    else $error("wake-up pulse longer than one cycle");

  eoc_low_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !eoc_valid_i)
    else $error("eoc_valid high during reset");

endmodule

bind mempool_system mempool_system_assert i_mempool_system_assert (
  .clk_i      (clk_i),
  .arst_n_i   (arst_n_i),
  .req_i      (req_i),
  .gnt_i      (gnt_o),
  .rvalid_i   (rvalid_o),
  .eoc_valid_i(eoc_valid_o),
  .wake_up_i  (wake_up_o)
);

//--- bench/tb_mempool_system.sv
//********************************************************************
// MemPool system testbench
// Random core traffic checked against a memory and register model
//********************************************************************
`timescale 1ns/1ns
module tb_mempool_system;
  import mempool_pkg::*;

  localparam int unsigned ClkPeriod  = 20;
  localparam int unsigned FillPerMst = 32;
  localparam int unsigned ReqPerMst  = 160;
  localparam int unsigned NumWords   = NumMasters * FillPerMst;
  localparam int unsigned TimeoutCyc = NumMasters * ReqPerMst * 40;

  // Request kinds
  localparam int KL2Wr   = 0;
  localparam int KL2Rd   = 1;
  localparam int KRomRd  = 2;
  localparam int KRomWr  = 3;
  localparam int KEocWr  = 4;
  localparam int KWakeWr = 5;
  localparam int KRegRd  = 6;
  localparam int KErrRd  = 7;

  logic                      clk;
  logic                      arst_n;
  logic [NumMasters-1:0]     req, we, gnt, rvalid;
  addr_t [NumMasters-1:0]    addr;
  data_t [NumMasters-1:0]    wdata, rdata;
  strb_t [NumMasters-1:0]    strb;
  data_t                     eoc;
  logic                      eoc_valid;
  logic [NumCores-1:0]       wake_up;

  integer              seed;
  int unsigned         errors;
  int unsigned         checks;
  // Model state
  data_t               l2_model [NumWords];
  data_t               eoc_model;
  logic [NumCores-1:0] wake_exp;
  data_t               exp_q [NumMasters][$];
  int                  kind_q [NumMasters][$];
  // Request held on each master until its grant
  int                  hk [NumMasters];
  int unsigned         hw [NumMasters];
  addr_t               ha [NumMasters];
  data_t               hd [NumMasters];
  strb_t               hs [NumMasters];
  bit [NumMasters-1:0] busy, acc, gap;
  int unsigned         sent [NumMasters];
  int unsigned         done_cnt [NumMasters];

  mempool_system dut_i (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .req_i      (req),
    .we_i       (we),
    .addr_i     (addr),
    .wdata_i    (wdata),
    .strb_i     (strb),
    .gnt_o      (gnt),
    .rvalid_o   (rvalid),
    .rdata_o    (rdata),
    .eoc_o      (eoc),
    .eoc_valid_o(eoc_valid),
    .wake_up_o  (wake_up)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  task automatic check_data(input string name, input data_t exp, input data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s at %0t: expected %h, actual %h", name, $time, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s at %0t: expected %b, actual %b", name, $time, exp, act);
    end
  endtask

  task automatic check_wake(input string name, input logic [NumCores-1:0] exp,
                            input logic [NumCores-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s at %0t: expected %b, actual %b", name, $time, exp, act);
    end
  endtask

  function automatic bit is_read(input int k);
    return (k == KL2Rd) || (k == KRomRd) || (k == KRegRd) || (k == KErrRd);
  endfunction

  function automatic string kind_name(input int k);
    case (k)
      KL2Rd:   return "l2_read";
      KRomRd:  return "rom_read";
      KRegRd:  return "reg_read";
      default: return "unmapped_read";
    endcase
  endfunction

  // Initial L2 contents, unique per address
  function automatic data_t fill_word(input addr_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_a5a5;
  endfunction

  // Expected register read at a control block offset
  function automatic data_t reg_expect(input addr_t off);
    case (off)
      EocOffset:      return eoc_model;
      L2StartOffset:  return L2MemoryBaseAddr;
      L2EndOffset:    return L2MemoryBaseAddr + L2Size;
      NumCoresOffset: return NumCores;
      default:        return '0;
    endcase
  endfunction

  // Shared resource of a request, one per interleaved L2 bank plus the SoC port
  function automatic int target_of(input addr_t a);
    addr_t off;
    off = a - L2MemoryBaseAddr;
    if (off < L2Size) return int'((off / 4) % NumL2Banks);
    return NumL2Banks;
  endfunction

  function automatic bit fill_done();
    for (int m = 0; m < NumMasters; m++) begin
      if (done_cnt[m] < FillPerMst) return 1'b0;
    end
    return 1'b1;
  endfunction

  function automatic bit all_done();
    for (int m = 0; m < NumMasters; m++) begin
      if (done_cnt[m] < ReqPerMst || exp_q[m].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic issue_request(input int m, input int k, input int unsigned w,
                               input addr_t a, input data_t d, input strb_t s);
    hk[m]    = k;
    hw[m]    = w;
    ha[m]    = a;
    hd[m]    = d;
    hs[m]    = s;
    busy[m]  = 1'b1;
    sent[m]++;
    req[m]   <= 1'b1;
    we[m]    <= !is_read(k);
    addr[m]  <= a;
    wdata[m] <= d;
    strb[m]  <= s;
  endtask

  task automatic fill_request(input int m);
    int unsigned w;
    addr_t       a;
    w = m * FillPerMst + sent[m];
    a = L2MemoryBaseAddr + 4 * w;
    issue_request(m, KL2Wr, w, a, fill_word(a), '1);
  endtask

  task automatic random_request(input int m);
    int          k;
    int unsigned w;
    addr_t       a;
    data_t       d;
    strb_t       s;
    k = {$random(seed)} % 8;
    w = {$random(seed)} % NumWords;
    d = $random(seed);
    s = strb_t'($random(seed));
    // Only core 0 wakes others, so pulses never overlap
    if (k == KWakeWr && m != 0) k = KEocWr;
    case (k)
      KL2Wr, KL2Rd:   a = L2MemoryBaseAddr + 4 * w;
      KRomRd, KRomWr: a = BootromBaseAddr + ({$random(seed)} & 32'h0000_fffc);
      KEocWr:         a = CtrlBaseAddr + EocOffset;
      KWakeWr:        a = CtrlBaseAddr + WakeUpOffset;
      KRegRd:         a = CtrlBaseAddr + 4 * ({$random(seed)} % 6);
      default:        a = 32'h1000_0000 + ({$random(seed)} & 32'h0000_fffc);
    endcase
    if (k == KWakeWr) gap[m] = 1'b1;
    issue_request(m, k, w, a, d, s);
  endtask

  // Model update in grant order, reads take the value at grant time
  task automatic apply_grant(input int m);
    data_t       e;
    int unsigned idx;
    e = '0;
    case (hk[m])
      KL2Wr: begin
        for (int i = 0; i < StrbWidth; i++) begin
          if (hs[m][i]) l2_model[hw[m]][8*i +: 8] = hd[m][8*i +: 8];
        end
      end
      KEocWr: begin
        for (int i = 0; i < StrbWidth; i++) begin
          if (hs[m][i]) eoc_model[8*i +: 8] = hd[m][8*i +: 8];
        end
      end
      KWakeWr: wake_exp = hd[m][NumCores-1:0];
      KL2Rd:   e = l2_model[hw[m]];
      KRomRd: begin
        idx = ((ha[m] - BootromBaseAddr) >> 2) % BootromNumWords;
        e   = BootromContent[idx];
      end
      KRegRd:  e = reg_expect(ha[m] - CtrlBaseAddr);
      KErrRd:  e = DecodeErrData;
      default: e = '0;
    endcase
    exp_q[m].push_back(e);
    kind_q[m].push_back(hk[m]);
    acc[m] = 1'b1;
    done_cnt[m]++;
  endtask

  task automatic check_cycle();
    int    k;
    data_t e;
    check_data("eoc", eoc_model, eoc);
    check_flag("eoc_valid", eoc_model[0], eoc_valid);
    check_wake("wake_up", wake_exp, wake_up);
    wake_exp = '0;
    // Each grant of the last cycle must answer now
    for (int m = 0; m < NumMasters; m++) begin
      if (exp_q[m].size() > 0) begin
        k = kind_q[m].pop_front();
        e = exp_q[m].pop_front();
        if (!rvalid[m]) begin
          errors++;
          $display("master %0d got no response one cycle after its grant", m);
        end else if (is_read(k)) begin
          check_data($sformatf("%s m%0d", kind_name(k), m), e, rdata[m]);
        end
      end else if (rvalid[m]) begin
        errors++;
        $display("master %0d got a response without a grant", m);
      end
    end
    // A bank or the SoC port serves one master per cycle
    for (int m = 0; m < NumMasters; m++) begin
      for (int n = m + 1; n < NumMasters; n++) begin
        if (gnt[m] && gnt[n] && target_of(ha[m]) == target_of(ha[n])) begin
          errors++;
          $display("masters %0d and %0d were granted the same target in one cycle", m, n);
        end
      end
    end
    for (int m = 0; m < NumMasters; m++) begin
      if (gnt[m]) apply_grant(m);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (arst_n) check_cycle();
  end

  always @(posedge clk) begin
    if (arst_n) begin
      for (int m = 0; m < NumMasters; m++) begin
        if (acc[m]) begin
          busy[m] = 1'b0;
          acc[m]  = 1'b0;
        end
        if (!busy[m]) begin
          if (sent[m] < FillPerMst) begin
            fill_request(m);
          end else if (!fill_done() || sent[m] >= ReqPerMst || gap[m] ||
                       (({$random(seed)} % 4) == 0)) begin
            req[m] <= 1'b0;
            gap[m] = 1'b0;
          end else begin
            random_request(m);
          end
        end
      end
    end
  end

  initial begin
    #(TimeoutCyc * ClkPeriod);
    $display("watchdog expired after %0d cycles with requests still open", TimeoutCyc);
    $display("checks %0d, errors %0d", checks, errors);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    seed      = 32'hc42c_6e9c;
    errors    = 0;
    checks    = 0;
    eoc_model = '0;
    wake_exp  = '0;
    busy      = '0;
    acc       = '0;
    gap       = '0;
    for (int m = 0; m < NumMasters; m++) begin
      sent[m]     = 0;
      done_cnt[m] = 0;
    end
    req    = '0;
    we     = '0;
    addr   = '0;
    wdata  = '0;
    strb   = '0;
    arst_n = 1'b0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    while (!all_done()) @(posedge clk);
    repeat (2) @(posedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
src/mempool_pkg.sv
src/mst_demux.sv
src/l2_xbar.sv
src/l2_bank.sv
src/soc_xbar.sv
src/bootrom.sv
src/ctrl_registers.sv
src/mempool_system.sv
bench/mempool_system_assert.sv
bench/tb_mempool_system.sv

//--- src/bootrom.sv
//********************************************************************
// Boot ROM
// Fixed boot code with a registered read
//********************************************************************
`timescale 1ns/1ns
module bootrom (
  input  logic                                    clk_i,
  input  logic                                    req_i,
  input  logic [mempool_pkg::BootromIdxWidth-1:0] addr_i,
  output mempool_pkg::data_t                      rdata_o
);
  import mempool_pkg::*;

  // Index width wraps the address onto the table
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= BootromContent[addr_i];
    end
  end

endmodule

//--- src/ctrl_registers.sv
//********************************************************************
// Control registers
// End of computation, core wake-up and system information
//********************************************************************
`timescale 1ns/1ns
module ctrl_registers (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [mempool_pkg::CtrlOffWidth-1:0] offset_i,
  input  mempool_pkg::data_t                   wdata_i,
  input  mempool_pkg::strb_t                   strb_i,
  output mempool_pkg::data_t                   rdata_o,
  output mempool_pkg::data_t                   eoc_o,
  output logic                                 eoc_valid_o,
  output logic [mempool_pkg::NumCores-1:0]     wake_up_o
);
  import mempool_pkg::*;

  data_t               eoc_q;
  logic [NumCores-1:0] wake_q;

  // Writes land on the grant edge, wake-up pulses for one cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      eoc_q  <= '0;
      wake_q <= '0;
    end else begin
      wake_q <= '0;
      if (req_i && we_i) begin
        if (offset_i == EocOffset) begin
          for (int i = 0; i < StrbWidth; i++) begin
            if (strb_i[i]) eoc_q[8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
        if (offset_i == WakeUpOffset) wake_q <= wdata_i[NumCores-1:0];
      end
    end
  end

  // Read data, wake-up and unknown offsets read as zero
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      case (offset_i)
        EocOffset:      rdata_o <= eoc_q;
        L2StartOffset:  rdata_o <= L2MemoryBaseAddr;
        L2EndOffset:    rdata_o <= L2MemoryBaseAddr + L2Size;
        NumCoresOffset: rdata_o <= data_t'(NumCores);
        default:        rdata_o <= '0;
      endcase
    end
  end

  assign eoc_o       = eoc_q;
  assign eoc_valid_o = eoc_q[0];
  assign wake_up_o   = wake_q;

endmodule

//--- src/l2_bank.sv
//********************************************************************
// L2 SRAM bank
// Single port, byte enables, one cycle read latency
//********************************************************************
`timescale 1ns/1ns
module l2_bank (
  input  logic                                clk_i,
  input  logic                                req_i,
  input  logic                                we_i,
  input  logic [mempool_pkg::L2BankAddrWidth-1:0] row_i,
  input  mempool_pkg::data_t                  wdata_i,
  input  mempool_pkg::strb_t                  strb_i,
  output mempool_pkg::data_t                  rdata_o
);
  import mempool_pkg::*;

  data_t mem [L2BankNumWords];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int i = 0; i < StrbWidth; i++) begin
          if (strb_i[i]) mem[row_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end else begin
        rdata_o <= mem[row_i];
      end
    end
  end

endmodule

//--- src/l2_xbar.sv
//********************************************************************
// L2 bank crossbar
// Round-robin arbitration per bank, registered response routing
//********************************************************************
`timescale 1ns/1ns
module l2_xbar (
  input  logic                                                  clk_i,
  input  logic                                                  arst_n_i,
  input  logic [mempool_pkg::NumMasters-1:0]                    req_i,
  input  logic [mempool_pkg::NumMasters-1:0]                    we_i,
  input  mempool_pkg::l2_addr_u [mempool_pkg::NumMasters-1:0]   addr_i,
  input  mempool_pkg::data_t [mempool_pkg::NumMasters-1:0]      wdata_i,
  input  mempool_pkg::strb_t [mempool_pkg::NumMasters-1:0]      strb_i,
  output logic [mempool_pkg::NumMasters-1:0]                    gnt_o,
  output logic [mempool_pkg::NumMasters-1:0]                    rvalid_o,
  output mempool_pkg::data_t [mempool_pkg::NumMasters-1:0]      rdata_o,
  output logic [mempool_pkg::NumL2Banks-1:0]                    bank_req_o,
  output logic [mempool_pkg::NumL2Banks-1:0]                    bank_we_o,
  output logic [mempool_pkg::NumL2Banks-1:0][mempool_pkg::L2BankAddrWidth-1:0] bank_row_o,
  output mempool_pkg::data_t [mempool_pkg::NumL2Banks-1:0]      bank_wdata_o,
  output mempool_pkg::strb_t [mempool_pkg::NumL2Banks-1:0]      bank_strb_o,
  input  mempool_pkg::data_t [mempool_pkg::NumL2Banks-1:0]      bank_rdata_i
);
  import mempool_pkg::*;

  logic     [NumL2Banks-1:0][NumMasters-1:0] bank_hit;
  mst_sel_t [NumL2Banks-1:0]                 bank_win;
  mst_sel_t [NumL2Banks-1:0]                 rr_q;
  mst_sel_t [NumL2Banks-1:0]                 win_q;
  logic     [NumL2Banks-1:0]                 vld_q;

  // Per bank arbitration and request mux
  always_comb begin
    for (int b = 0; b < NumL2Banks; b++) begin
      for (int m = 0; m < NumMasters; m++) begin
        bank_hit[b][m] = req_i[m] && (addr_i[m].split.bank == b);
      end
      bank_win[b]     = rr_pick(bank_hit[b], rr_q[b]);
      bank_req_o[b]   = |bank_hit[b];
      bank_we_o[b]    = we_i[bank_win[b]];
      bank_row_o[b]   = addr_i[bank_win[b]].split.row;
      bank_wdata_o[b] = wdata_i[bank_win[b]];
      bank_strb_o[b]  = strb_i[bank_win[b]];
    end
  end

  // A master is granted when its bank picked it
  always_comb begin
    for (int m = 0; m < NumMasters; m++) begin
      gnt_o[m] = req_i[m] && bank_req_o[addr_i[m].split.bank] &&
                 (bank_win[addr_i[m].split.bank] == m);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q  <= '0;
      win_q <= '0;
      vld_q <= '0;
    end else begin
      vld_q <= bank_req_o;
      win_q <= bank_win;
      for (int b = 0; b < NumL2Banks; b++) begin
        if (bank_req_o[b]) rr_q[b] <= mst_sel_t'((bank_win[b] + 1) % NumMasters);
      end
    end
  end

  // Bank data goes back to the master that won the previous cycle
  always_comb begin
    rvalid_o = '0;
    rdata_o  = '0;
    for (int b = 0; b < NumL2Banks; b++) begin
      if (vld_q[b]) begin
        rvalid_o[win_q[b]] = 1'b1;
        rdata_o[win_q[b]]  = bank_rdata_i[b];
      end
    end
  end

endmodule

//--- src/mempool_pkg.sv
//********************************************************************
// MemPool system package
// Address map, bus widths, L2 bank geometry and boot ROM contents
//********************************************************************
package mempool_pkg;

  // Bus widths and counts
  localparam int unsigned AddrWidth       = 32;
  localparam int unsigned DataWidth       = 32;
  localparam int unsigned StrbWidth       = DataWidth / 8;
  localparam int unsigned ByteOffWidth    = $clog2(StrbWidth);
  localparam int unsigned NumMasters      = 2;
  localparam int unsigned NumCores        = 4;
  localparam int unsigned NumL2Banks      = 4;
  localparam int unsigned L2BankNumWords  = 256;
  localparam int unsigned L2BankAddrWidth = 8;
  localparam int unsigned L2BankSelWidth  = 2;

  typedef logic [AddrWidth-1:0]          addr_t;
  typedef logic [DataWidth-1:0]          data_t;
  typedef logic [StrbWidth-1:0]          strb_t;
  typedef logic [$clog2(NumMasters)-1:0] mst_sel_t;

  // Address map
  localparam addr_t       L2MemoryBaseAddr = 32'h8000_0000;
  localparam addr_t       L2Size           = 32'h0000_1000;
  localparam addr_t       BootromBaseAddr  = 32'hA000_0000;
  localparam addr_t       BootromSize      = 32'h0001_0000;
  localparam int unsigned BootromNumWords  = 8;
  localparam int unsigned BootromIdxWidth  = $clog2(BootromNumWords);
  localparam addr_t       CtrlBaseAddr     = 32'h4000_0000;
  localparam addr_t       CtrlSize         = 32'h0001_0000;
  localparam int unsigned CtrlOffWidth     = $clog2(CtrlSize);

  // Control register offsets
  localparam int unsigned EocOffset      = 'h00;
  localparam int unsigned WakeUpOffset   = 'h04;
  localparam int unsigned L2StartOffset  = 'h08;
  localparam int unsigned L2EndOffset    = 'h0C;
  localparam int unsigned NumCoresOffset = 'h10;

  // Answer for reads that hit no target
  localparam data_t DecodeErrData = 32'hBADC_AB1E;

  // Boot code, parks every core in a wfi loop
  localparam data_t BootromContent [BootromNumWords] = '{
    32'hf140_2573, 32'h0000_0597, 32'h0185_8593, 32'h3055_9073,
    32'h3040_5073, 32'h1050_0073, 32'hffdf_f06f, 32'h0000_0013
  };

  // L2 byte offset, flat or split into row, bank and byte
  typedef union packed {
    logic [L2BankAddrWidth+L2BankSelWidth+ByteOffWidth-1:0] flat;
    struct packed {
      logic [L2BankAddrWidth-1:0] row;
      logic [L2BankSelWidth-1:0]  bank;
      logic [ByteOffWidth-1:0]    byte_off;
    } split;
  } l2_addr_u;

  // First requester at or after the pointer wins
  function automatic mst_sel_t rr_pick(logic [NumMasters-1:0] req, mst_sel_t ptr);
    mst_sel_t idx;
    mst_sel_t win;
    win = ptr;
    for (int k = NumMasters - 1; k >= 0; k--) begin
      idx = mst_sel_t'((ptr + k) % NumMasters);
      if (req[idx]) win = idx;
    end
    return win;
  endfunction

endpackage

//--- src/mempool_system.sv
//********************************************************************
// MemPool system top
// Demuxes, crossbars, L2 banks, boot ROM and control registers
//********************************************************************
`timescale 1ns/1ns
module mempool_system (
  input  logic                                             clk_i,
  input  logic                                             arst_n_i,
  input  logic [mempool_pkg::NumMasters-1:0]               req_i,
  input  logic [mempool_pkg::NumMasters-1:0]               we_i,
  input  mempool_pkg::addr_t [mempool_pkg::NumMasters-1:0] addr_i,
  input  mempool_pkg::data_t [mempool_pkg::NumMasters-1:0] wdata_i,
  input  mempool_pkg::strb_t [mempool_pkg::NumMasters-1:0] strb_i,
  output logic [mempool_pkg::NumMasters-1:0]               gnt_o,
  output logic [mempool_pkg::NumMasters-1:0]               rvalid_o,
  output mempool_pkg::data_t [mempool_pkg::NumMasters-1:0] rdata_o,
  output mempool_pkg::data_t                               eoc_o,
  output logic                                             eoc_valid_o,
  output logic [mempool_pkg::NumCores-1:0]                 wake_up_o
);
  import mempool_pkg::*;

  // Demux to L2 crossbar
  logic     [NumMasters-1:0] l2_req, l2_we, l2_gnt, l2_rvalid;
  l2_addr_u [NumMasters-1:0] l2_addr;
  data_t    [NumMasters-1:0] l2_wdata, l2_rdata;
  strb_t    [NumMasters-1:0] l2_strb;
  // Demux to SoC crossbar
  logic     [NumMasters-1:0] soc_req, soc_we, soc_gnt, soc_rvalid;
  addr_t    [NumMasters-1:0] soc_addr;
  data_t    [NumMasters-1:0] soc_wdata, soc_rdata;
  strb_t    [NumMasters-1:0] soc_strb;
  // L2 crossbar to banks
  logic [NumL2Banks-1:0]                      bank_req, bank_we;
  logic [NumL2Banks-1:0][L2BankAddrWidth-1:0] bank_row;
  data_t [NumL2Banks-1:0]                     bank_wdata, bank_rdata;
  strb_t [NumL2Banks-1:0]                     bank_strb;
  // SoC targets
  logic                       rom_req;
  logic [BootromIdxWidth-1:0] rom_addr;
  data_t                      rom_rdata;
  logic                       reg_req;
  logic                       reg_we;
  logic [CtrlOffWidth-1:0]    reg_offset;
  data_t                      reg_wdata;
  data_t                      reg_rdata;
  strb_t                      reg_strb;

  for (genvar i = 0; i < NumMasters; i++) begin : gen_mst_demux
    mst_demux i_mst_demux (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .req_i       (req_i[i]),
      .we_i        (we_i[i]),
      .addr_i      (addr_i[i]),
      .wdata_i     (wdata_i[i]),
      .strb_i      (strb_i[i]),
      .gnt_o       (gnt_o[i]),
      .rvalid_o    (rvalid_o[i]),
      .rdata_o     (rdata_o[i]),
      .l2_req_o    (l2_req[i]),
      .l2_we_o     (l2_we[i]),
      .l2_addr_o   (l2_addr[i]),
      .l2_wdata_o  (l2_wdata[i]),
      .l2_strb_o   (l2_strb[i]),
      .l2_gnt_i    (l2_gnt[i]),
      .l2_rvalid_i (l2_rvalid[i]),
      .l2_rdata_i  (l2_rdata[i]),
      .soc_req_o   (soc_req[i]),
      .soc_we_o    (soc_we[i]),
      .soc_addr_o  (soc_addr[i]),
      .soc_wdata_o (soc_wdata[i]),
      .soc_strb_o  (soc_strb[i]),
      .soc_gnt_i   (soc_gnt[i]),
      .soc_rvalid_i(soc_rvalid[i]),
      .soc_rdata_i (soc_rdata[i])
    );
  end

  l2_xbar i_l2_xbar (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (l2_req),
    .we_i        (l2_we),
    .addr_i      (l2_addr),
    .wdata_i     (l2_wdata),
    .strb_i      (l2_strb),
    .gnt_o       (l2_gnt),
    .rvalid_o    (l2_rvalid),
    .rdata_o     (l2_rdata),
    .bank_req_o  (bank_req),
    .bank_we_o   (bank_we),
    .bank_row_o  (bank_row),
    .bank_wdata_o(bank_wdata),
    .bank_strb_o (bank_strb),
    .bank_rdata_i(bank_rdata)
  );

  for (genvar b = 0; b < NumL2Banks; b++) begin : gen_l2_banks
    l2_bank i_l2_bank (
      .clk_i  (clk_i),
      .req_i  (bank_req[b]),
      .we_i   (bank_we[b]),
      .row_i  (bank_row[b]),
      .wdata_i(bank_wdata[b]),
      .strb_i (bank_strb[b]),
      .rdata_o(bank_rdata[b])
    );
  end

  soc_xbar i_soc_xbar (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (soc_req),
    .we_i        (soc_we),
    .addr_i      (soc_addr),
    .wdata_i     (soc_wdata),
    .strb_i      (soc_strb),
    .gnt_o       (soc_gnt),
    .rvalid_o    (soc_rvalid),
    .rdata_o     (soc_rdata),
    .rom_req_o   (rom_req),
    .rom_addr_o  (rom_addr),
    .rom_rdata_i (rom_rdata),
    .reg_req_o   (reg_req),
    .reg_we_o    (reg_we),
    .reg_offset_o(reg_offset),
    .reg_wdata_o (reg_wdata),
    .reg_strb_o  (reg_strb),
    .reg_rdata_i (reg_rdata)
  );

  bootrom i_bootrom (
    .clk_i  (clk_i),
    .req_i  (rom_req),
    .addr_i (rom_addr),
    .rdata_o(rom_rdata)
  );

  ctrl_registers i_ctrl_registers (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (reg_req),
    .we_i       (reg_we),
    .offset_i   (reg_offset),
    .wdata_i    (reg_wdata),
    .strb_i     (reg_strb),
    .rdata_o    (reg_rdata),
    .eoc_o      (eoc_o),
    .eoc_valid_o(eoc_valid_o),
    .wake_up_o  (wake_up_o)
  );

endmodule

//--- src/mst_demux.sv
//********************************************************************
// Per-master demux
// Steers each request to L2 or to the SoC crossbar by address
//********************************************************************
`timescale 1ns/1ns
module mst_demux (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  req_i,
  input  logic                  we_i,
  input  mempool_pkg::addr_t    addr_i,
  input  mempool_pkg::data_t    wdata_i,
  input  mempool_pkg::strb_t    strb_i,
  output logic                  gnt_o,
  output logic                  rvalid_o,
  output mempool_pkg::data_t    rdata_o,
  output logic                  l2_req_o,
  output logic                  l2_we_o,
  output mempool_pkg::l2_addr_u l2_addr_o,
  output mempool_pkg::data_t    l2_wdata_o,
  output mempool_pkg::strb_t    l2_strb_o,
  input  logic                  l2_gnt_i,
  input  logic                  l2_rvalid_i,
  input  mempool_pkg::data_t    l2_rdata_i,
  output logic                  soc_req_o,
  output logic                  soc_we_o,
  output mempool_pkg::addr_t    soc_addr_o,
  output mempool_pkg::data_t    soc_wdata_o,
  output mempool_pkg::strb_t    soc_strb_o,
  input  logic                  soc_gnt_i,
  input  logic                  soc_rvalid_i,
  input  mempool_pkg::data_t    soc_rdata_i
);
  import mempool_pkg::*;

  addr_t l2_off;
  logic  l2_hit;
  logic  l2_sel_q;

  // Anything outside the L2 window goes to the SoC side
  assign l2_off         = addr_i - L2MemoryBaseAddr;
  assign l2_hit         = l2_off < L2Size;
  assign l2_addr_o.flat = l2_off[$bits(l2_addr_u)-1:0];

  assign l2_req_o    = req_i & l2_hit;
  assign l2_we_o     = we_i;
  assign l2_wdata_o  = wdata_i;
  assign l2_strb_o   = strb_i;
  assign soc_req_o   = req_i & ~l2_hit;
  assign soc_we_o    = we_i;
  assign soc_addr_o  = addr_i;
  assign soc_wdata_o = wdata_i;
  assign soc_strb_o  = strb_i;

  assign gnt_o = l2_hit ? l2_gnt_i : soc_gnt_i;

  // Remember the granted side for the response cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      l2_sel_q <= 1'b0;
    end else if (req_i && gnt_o) begin
      l2_sel_q <= l2_hit;
    end
  end

  assign rvalid_o = l2_sel_q ? l2_rvalid_i : soc_rvalid_i;
  assign rdata_o  = l2_sel_q ? l2_rdata_i : soc_rdata_i;

endmodule

//--- src/soc_xbar.sv
//********************************************************************
// SoC crossbar
// Shared port for boot ROM, control registers and decode errors
//********************************************************************
`timescale 1ns/1ns
module soc_xbar (
  input  logic                                             clk_i,
  input  logic                                             arst_n_i,
  input  logic [mempool_pkg::NumMasters-1:0]               req_i,
  input  logic [mempool_pkg::NumMasters-1:0]               we_i,
  input  mempool_pkg::addr_t [mempool_pkg::NumMasters-1:0] addr_i,
  input  mempool_pkg::data_t [mempool_pkg::NumMasters-1:0] wdata_i,
  input  mempool_pkg::strb_t [mempool_pkg::NumMasters-1:0] strb_i,
  output logic [mempool_pkg::NumMasters-1:0]               gnt_o,
  output logic [mempool_pkg::NumMasters-1:0]               rvalid_o,
  output mempool_pkg::data_t [mempool_pkg::NumMasters-1:0] rdata_o,
  output logic                                             rom_req_o,
  output logic [mempool_pkg::BootromIdxWidth-1:0]          rom_addr_o,
  input  mempool_pkg::data_t                               rom_rdata_i,
  output logic                                             reg_req_o,
  output logic                                             reg_we_o,
  output logic [mempool_pkg::CtrlOffWidth-1:0]             reg_offset_o,
  output mempool_pkg::data_t                               reg_wdata_o,
  output mempool_pkg::strb_t                               reg_strb_o,
  input  mempool_pkg::data_t                               reg_rdata_i
);
  import mempool_pkg::*;

  logic     any_req;
  mst_sel_t win;
  addr_t    rom_off;
  addr_t    reg_off;
  logic     hit_rom;
  logic     hit_reg;
  mst_sel_t rr_q;
  mst_sel_t win_q;
  logic     vld_q;
  logic     rom_q;
  logic     reg_q;
  data_t    resp_data;

  assign any_req = |req_i;
  assign win     = rr_pick(req_i, rr_q);

  always_comb begin
    for (int m = 0; m < NumMasters; m++) begin
      gnt_o[m] = any_req && (win == m);
    end
  end

  // Address decode of the winning request
  assign rom_off = addr_i[win] - BootromBaseAddr;
  assign reg_off = addr_i[win] - CtrlBaseAddr;
  assign hit_rom = rom_off < BootromSize;
  assign hit_reg = reg_off < CtrlSize;

  // ROM writes are dropped here but still acknowledged
  assign rom_req_o    = any_req & hit_rom & ~we_i[win];
  assign rom_addr_o   = rom_off[ByteOffWidth +: BootromIdxWidth];
  assign reg_req_o    = any_req & hit_reg;
  assign reg_we_o     = we_i[win];
  assign reg_offset_o = reg_off[CtrlOffWidth-1:0];
  assign reg_wdata_o  = wdata_i[win];
  assign reg_strb_o   = strb_i[win];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q  <= '0;
      win_q <= '0;
      vld_q <= 1'b0;
      rom_q <= 1'b0;
      reg_q <= 1'b0;
    end else begin
      vld_q <= any_req;
      win_q <= win;
      rom_q <= hit_rom;
      reg_q <= hit_reg;
      if (any_req) rr_q <= mst_sel_t'((win + 1) % NumMasters);
    end
  end

  assign resp_data = rom_q ? rom_rdata_i : (reg_q ? reg_rdata_i : DecodeErrData);

  always_comb begin
    for (int m = 0; m < NumMasters; m++) begin
      rvalid_o[m] = vld_q && (win_q == m);
      rdata_o[m]  = resp_data;
    end
  end

endmodule
